/* sources.f */
+incdir+verification
design/lsu_pkg.sv
design/store_queue.sv
design/load_unit.sv
design/apb_mem_port.sv
design/lsu_top.sv
verification/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the LSU testbench with Verilator and runs it from the project root.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build did not complete"
  exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* verification/lsu_model.svh */
// Reference model of the store queue and of memory, included inside lsu_tb.
// It uses the AW and DW widths that lsu_tb declares before the include.
// A word that was never written reads back a fill pattern of its whole address.

`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

// stores in program order, oldest first. The oldest mq_retired of them are retired.
logic [AW-1:0] mq_addr [$];
logic [DW-1:0] mq_data [$];
int            mq_retired = 0;
// memory as the completed APB writes have left it.
logic [DW-1:0] ref_mem [logic [AW-1:0]];

function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] addr);
  return {addr ^ 32'h5a5a_c3c3, ~addr};
endfunction

function automatic logic [DW-1:0] ref_read(input logic [AW-1:0] addr);
  if (ref_mem.exists(addr)) begin
    return ref_mem[addr];
  end
  return fill_word(addr);
endfunction

function automatic int unretired();
  return mq_addr.size() - mq_retired;
endfunction

function automatic void model_push(input logic [AW-1:0] addr, input logic [DW-1:0] data);
  mq_addr.push_back(addr);
  mq_data.push_back(data);
endfunction

// the oldest retired store reaches memory.
function automatic void drain_head();
  ref_mem[mq_addr[0]] = mq_data[0];
  void'(mq_addr.pop_front());
  void'(mq_data.pop_front());
  mq_retired--;
endfunction

// a load sees the youngest queued store to its address, else memory.
function automatic void expect_load(input logic [AW-1:0] addr, output bit hit,
                                    output logic [DW-1:0] data);
  hit  = 1'b0;
  data = ref_read(addr);
  foreach (mq_addr[i]) begin
    if (mq_addr[i] == addr) begin
      hit  = 1'b1;
      data = mq_data[i];
    end
  end
endfunction

`endif

/* verification/lsu_tb.sv */
// Testbench for lsu_top at the default store queue depth.
// It plays the APB slave with a sparse memory and 0 to 3 wait states.
// Stimulus, the slave and all checks run in one thread on the falling edge.

`timescale 1ns/100ps

module lsu_tb;

  localparam int AW         = lsu_pkg::ADDR_W;
  localparam int DW         = lsu_pkg::DATA_W;
  localparam int DSW        = lsu_pkg::DISP_W;
  localparam int TW         = lsu_pkg::TAG_W;
  localparam int DEPTH      = lsu_pkg::SQ_DEPTH_DEFAULT;
  localparam int MIX_OPS    = 400;
  localparam int DRAIN_OPS  = 12;
  localparam int TOTAL_OPS  = 6 + DRAIN_OPS + DEPTH + MIX_OPS;
  localparam int MAX_CYCLES = TOTAL_OPS * 40;

  logic           clk = 1'b0;
  logic           rst;
  logic           op_vld_i;
  logic           op_is_st_i;
  logic [AW-1:0]  base_i;
  logic [DW-1:0]  st_data_i;
  logic [DSW-1:0] disp_i;
  logic [TW-1:0]  tag_i;
  logic           retire_st_i;
  logic [DW-1:0]  prdata_i;
  logic           pready_i;
  logic           op_rdy_o;
  logic           result_vld_o;
  logic [DW-1:0]  result_data_o;
  logic [TW-1:0]  result_tag_o;
  logic           sq_empty_o;
  logic           psel_o;
  logic           penable_o;
  logic           pwrite_o;
  logic [AW-1:0]  paddr_o;
  logic [DW-1:0]  pwdata_o;

  int             wd_cycles = 0;
  int             errors = 0;
  int             errors_before = 0;
  int             n_ops = 0;
  int             n_loads = 0;
  int             wait_left = 0;
  // the load in flight and what it must return.
  bit             ld_pend = 1'b0;
  bit             ld_fwd = 1'b0;
  bit             rd_seen;
  logic [AW-1:0]  ld_addr;
  logic [DW-1:0]  ld_exp;
  logic [TW-1:0]  ld_tag;
  // APB write that completes on the coming rising edge.
  bit             wr_pend = 1'b0;
  logic [AW-1:0]  wr_addr;
  logic [DW-1:0]  wr_data;
  logic [DW-1:0]  apb_mem [logic [AW-1:0]];

  `include "lsu_model.svh"

  lsu_top #(.SQ_DEPTH(DEPTH)) u_dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    wd_cycles <= wd_cycles + 1;
    if (wd_cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles", wd_cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic log_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // ******************************************************************
  // per-cycle work: model update, result check and APB slave
  // ******************************************************************

  // the DUT queue drops the store on the edge the write ends, so the model follows one tick later.
  task automatic commit_write();
    if (wr_pend) begin
      wr_pend = 1'b0;
      assert (mq_retired > 0) else log_error($sformatf(
        "APB write to %h with no retired store waiting", wr_addr));
      if (mq_retired > 0) begin
        assert (wr_addr == mq_addr[0]) else log_error($sformatf(
          "mismatch paddr_o: got %h expected %h", wr_addr, mq_addr[0]));
        assert (wr_data == mq_data[0]) else log_error($sformatf(
          "mismatch pwdata_o: got %h expected %h", wr_data, mq_data[0]));
        drain_head();
      end
    end
  endtask

  task automatic check_result();
    if (ld_pend && ld_fwd) begin
      assert (result_vld_o) else log_error("no result one cycle after a forwarded load");
    end
    if (result_vld_o) begin
      assert (ld_pend) else log_error("result_vld_o pulsed with no load in flight");
      assert (result_data_o == ld_exp) else log_error($sformatf(
        "mismatch result_data_o: got %h expected %h", result_data_o, ld_exp));
      assert (result_tag_o == ld_tag) else log_error($sformatf(
        "mismatch result_tag_o: got %h expected %h", result_tag_o, ld_tag));
      assert (ld_fwd || rd_seen) else log_error($sformatf(
        "load of %h returned before an APB read of that address", ld_addr));
      n_loads++;
    end
    if (result_vld_o || ld_fwd) begin
      ld_pend = 1'b0;
    end
  endtask

  task automatic serve_apb();
    pready_i = 1'b0;
    if (psel_o && !penable_o) begin
      wait_left = $urandom_range(3, 0);
    end else if (psel_o && wait_left > 0) begin
      wait_left--;
    end else if (psel_o) begin
      pready_i = 1'b1;
      if (pwrite_o) begin
        apb_mem[paddr_o] = pwdata_o;
        wr_pend = 1'b1;
        wr_addr = paddr_o;
        wr_data = pwdata_o;
      end else begin
        prdata_i = apb_mem.exists(paddr_o) ? apb_mem[paddr_o] : fill_word(paddr_o);
        rd_seen  = rd_seen | (ld_pend && paddr_o == ld_addr);
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);
    op_vld_i    = 1'b0;
    retire_st_i = 1'b0;
    commit_write();
    check_result();
    serve_apb();
  endtask

  // ******************************************************************
  // stimulus
  // ******************************************************************

  // retire_st_i is a single pulse, so at most one store retires per cycle.
  task automatic retire_one();
    if (unretired() > 0 && !retire_st_i) begin
      retire_st_i = 1'b1;
      mq_retired++;
    end
  endtask

  task automatic issue_op(input bit is_st, input logic [AW-1:0] addr);
    logic [31:0]   rnd;
    logic [DW-1:0] data;
    bit            hit;
    while (!op_rdy_o) begin
      if ($urandom_range(1, 0) == 1) begin
        retire_one();
      end
      tick();
    end
    rnd        = $urandom();
    data       = {$urandom(), $urandom()};
    disp_i     = rnd[DSW-1:0];
    base_i     = addr - {{(AW-DSW){rnd[DSW-1]}}, rnd[DSW-1:0]};
    tag_i      = rnd[DSW+TW-1:DSW];
    st_data_i  = data;
    op_is_st_i = is_st;
    op_vld_i   = 1'b1;
    n_ops++;
    if (is_st) begin
      model_push(addr, data);
    end else begin
      expect_load(addr, hit, ld_exp);
      ld_pend = 1'b1;
      ld_fwd  = hit;
      ld_addr = addr;
      ld_tag  = tag_i;
      rd_seen = 1'b0;
    end
    tick();
  endtask

  // retires every store, waits for the queue to empty and compares memories.
  task automatic drain_all();
    while (ld_pend) begin
      tick();
    end
    while (unretired() > 0) begin
      retire_one();
      tick();
    end
    while (!sq_empty_o) begin
      tick();
    end
    assert (mq_addr.size() == 0) else log_error("sq_empty_o high while stores are queued");
    assert (apb_mem.num() == ref_mem.num()) else log_error("memory word counts differ");
    foreach (apb_mem[a]) begin
      assert (apb_mem[a] == ref_read(a)) else log_error($sformatf(
        "mismatch mem[%h]: got %h expected %h", a, apb_mem[a], ref_read(a)));
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, errors - errors_before);
    errors_before = errors;
  endtask

  function automatic logic [AW-1:0] pool_addr();
    return 32'h0000_1000 + 8 * $urandom_range(7, 0);
  endfunction

  initial begin
    logic [AW-1:0] a;
    void'($urandom(36842));
    rst         = 1'b1;
    op_vld_i    = 1'b0;
    op_is_st_i  = 1'b0;
    base_i      = '0;
    st_data_i   = '0;
    disp_i      = '0;
    tag_i       = '0;
    retire_st_i = 1'b0;
    prdata_i    = '0;
    pready_i    = 1'b0;
    repeat (5) begin
      tick();
    end
    assert (!op_rdy_o && !result_vld_o && !psel_o && !penable_o) else
      log_error("outputs not low during reset");
    rst = 1'b0;
    tick();

    a = pool_addr();
    issue_op(1'b1, a);
    issue_op(1'b1, a + 8);
    issue_op(1'b1, a);
    issue_op(1'b0, a);
    drain_all();
    end_test("forwarding");

    issue_op(1'b0, 32'h0004_0000 + 8 * $urandom_range(255, 0));
    issue_op(1'b0, a);
    drain_all();
    end_test("memory load");

    repeat (DRAIN_OPS) begin
      if ($urandom_range(1, 0) == 1) begin
        retire_one();
      end
      issue_op(1'b1, pool_addr());
    end
    drain_all();
    end_test("in-order drain");

    repeat (DEPTH) begin
      issue_op(1'b1, pool_addr());
    end
    repeat (4) begin
      assert (!op_rdy_o) else log_error("op_rdy_o high with a full store queue");
      tick();
    end
    retire_one();
    tick();
    while (!op_rdy_o) begin
      tick();
    end
    assert (mq_addr.size() < DEPTH) else log_error("op_rdy_o rose before a store drained");
    drain_all();
    end_test("back-pressure");

    repeat (MIX_OPS) begin
      if ($urandom_range(2, 0) == 0) begin
        retire_one();
      end
      issue_op($urandom_range(1, 0) == 1, pool_addr());
    end
    drain_all();
    end_test("random mix");

    $display("summary: %0d operations, %0d load results, %0d errors", n_ops, n_loads, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* design/lsu_top.sv */
// Load/store functional unit. Operations arrive in program order.
// Only one load is in flight at a time. Stores wait in the queue until retired.
// The APB slave must not signal errors, and PSLVERR is not observed.

`timescale 1ns/100ps

module lsu_top #(
  parameter int SQ_DEPTH = lsu_pkg::SQ_DEPTH_DEFAULT
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       op_vld_i,
  input  logic                       op_is_st_i,
  input  logic [lsu_pkg::ADDR_W-1:0] base_i,
  input  logic [lsu_pkg::DATA_W-1:0] st_data_i,
  input  logic [lsu_pkg::DISP_W-1:0] disp_i,
  input  logic [lsu_pkg::TAG_W-1:0]  tag_i,
  input  logic                       retire_st_i,
  input  logic [lsu_pkg::DATA_W-1:0] prdata_i,
  input  logic                       pready_i,
  output logic                       op_rdy_o,
  output logic                       result_vld_o,
  output logic [lsu_pkg::DATA_W-1:0] result_data_o,
  output logic [lsu_pkg::TAG_W-1:0]  result_tag_o,
  output logic                       sq_empty_o,
  output logic                       psel_o,
  output logic                       penable_o,
  output logic                       pwrite_o,
  output logic [lsu_pkg::ADDR_W-1:0] paddr_o,
  output logic [lsu_pkg::DATA_W-1:0] pwdata_o
);

  logic                       rdy_q;
  logic                       accept;
  logic                       sq_push;
  logic                       ld_push;
  logic                       sq_full;
  logic                       ld_busy;
  logic [lsu_pkg::ADDR_W-1:0] addr;
  logic [lsu_pkg::ADDR_W-1:0] fwd_addr;
  logic                       fwd_hit;
  logic [lsu_pkg::DATA_W-1:0] fwd_data;
  logic                       drain_req;
  logic                       drain_ack;
  logic [lsu_pkg::ADDR_W-1:0] drain_addr;
  logic [lsu_pkg::DATA_W-1:0] drain_data;
  logic                       rd_req;
  logic                       rd_ack;
  logic [lsu_pkg::ADDR_W-1:0] rd_addr;
  logic [lsu_pkg::DATA_W-1:0] rd_data;

  // effective address is base plus the sign-extended displacement.
  assign addr = base_i +
                {{(lsu_pkg::ADDR_W-lsu_pkg::DISP_W){disp_i[lsu_pkg::DISP_W-1]}}, disp_i};

  // rdy_q holds ready low through reset and for the first cycle after it.
  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
    end
  end

  assign op_rdy_o = rdy_q & ~sq_full & ~ld_busy;
  assign accept   = op_vld_i & op_rdy_o;
  assign sq_push  = accept & (op_is_st_i == lsu_pkg::OP_STORE);
  assign ld_push  = accept & (op_is_st_i == lsu_pkg::OP_LOAD);

  store_queue #(
    .SQ_DEPTH (SQ_DEPTH)
  ) u_sq (
    .clk          (clk),
    .rst          (rst),
    .push_i       (sq_push),
    .addr_i       (addr),
    .data_i       (st_data_i),
    .retire_i     (retire_st_i),
    .fwd_addr_i   (fwd_addr),
    .drain_ack_i  (drain_ack),
    .full_o       (sq_full),
    .empty_o      (sq_empty_o),
    .fwd_hit_o    (fwd_hit),
    .fwd_data_o   (fwd_data),
    .drain_req_o  (drain_req),
    .drain_addr_o (drain_addr),
    .drain_data_o (drain_data)
  );

  load_unit u_ld (
    .clk           (clk),
    .rst           (rst),
    .ld_i          (ld_push),
    .addr_i        (addr),
    .tag_i         (tag_i),
    .fwd_hit_i     (fwd_hit),
    .fwd_data_i    (fwd_data),
    .rd_ack_i      (rd_ack),
    .rd_data_i     (rd_data),
    .busy_o        (ld_busy),
    .fwd_addr_o    (fwd_addr),
    .rd_req_o      (rd_req),
    .rd_addr_o     (rd_addr),
    .result_vld_o  (result_vld_o),
    .result_data_o (result_data_o),
    .result_tag_o  (result_tag_o)
  );

  apb_mem_port u_apb (
    .clk          (clk),
    .rst          (rst),
    .drain_req_i  (drain_req),
    .drain_addr_i (drain_addr),
    .drain_data_i (drain_data),
    .rd_req_i     (rd_req),
    .rd_addr_i    (rd_addr),
    .prdata_i     (prdata_i),
    .pready_i     (pready_i),
    .drain_ack_o  (drain_ack),
    .rd_ack_o     (rd_ack),
    .rd_data_o    (rd_data),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .pwrite_o     (pwrite_o),
    .paddr_o      (paddr_o),
    .pwdata_o     (pwdata_o)
  );

endmodule

/* design/apb_mem_port.sv */
// APB master shared by store drains and load reads.
// One transfer at a time. When both sides wait, the grant alternates.
// PSLVERR is not supported, and every transfer is taken as successful.

`timescale 1ns/100ps

module apb_mem_port (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       drain_req_i,
  input  logic [lsu_pkg::ADDR_W-1:0] drain_addr_i,
  input  logic [lsu_pkg::DATA_W-1:0] drain_data_i,
  input  logic                       rd_req_i,
  input  logic [lsu_pkg::ADDR_W-1:0] rd_addr_i,
  input  logic [lsu_pkg::DATA_W-1:0] prdata_i,
  input  logic                       pready_i,
  output logic                       drain_ack_o,
  output logic                       rd_ack_o,
  output logic [lsu_pkg::DATA_W-1:0] rd_data_o,
  output logic                       psel_o,
  output logic                       penable_o,
  output logic                       pwrite_o,
  output logic [lsu_pkg::ADDR_W-1:0] paddr_o,
  output logic [lsu_pkg::DATA_W-1:0] pwdata_o
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_t;

  state_t                     state_q;
  logic                       sel_rd_q;
  logic                       last_rd_q;
  logic                       pick_rd;
  logic [lsu_pkg::ADDR_W-1:0] paddr_q;
  logic [lsu_pkg::DATA_W-1:0] pwdata_q;
  logic                       done;

  // a lone requester wins, otherwise serve the side not served last.
  assign pick_rd = rd_req_i & (~drain_req_i | ~last_rd_q);
  assign done    = (state_q == ACCESS) & pready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      sel_rd_q  <= 1'b0;
      last_rd_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (rd_req_i || drain_req_i) begin
            state_q   <= SETUP;
            sel_rd_q  <= pick_rd;
            last_rd_q <= pick_rd;
          end
        end
        SETUP:   state_q <= ACCESS;
        ACCESS:  state_q <= pready_i ? IDLE : ACCESS;
        default: state_q <= IDLE;
      endcase
    end
  end

  // address and write data are captured once and held for the whole transfer.
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      paddr_q  <= pick_rd ? rd_addr_i : drain_addr_i;
      pwdata_q <= drain_data_i;
    end
  end

  assign psel_o      = (state_q != IDLE);
  assign penable_o   = (state_q == ACCESS);
  assign pwrite_o    = ~sel_rd_q;
  assign paddr_o     = paddr_q;
  assign pwdata_o    = pwdata_q;
  assign drain_ack_o = done & ~sel_rd_q;
  assign rd_ack_o    = done & sel_rd_q;
  assign rd_data_o   = prdata_i;

  a_access_stable: assert property (@(posedge clk) disable iff (rst)
    penable_o |-> ($past(psel_o) && $stable(paddr_o) && $stable(pwrite_o) &&
                   $stable(pwdata_o)));

  // the granted side keeps its request up until its transfer ends.
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    psel_o |-> (sel_rd_q ? rd_req_i : drain_req_i));

endmodule

/* design/load_unit.sv */
// Single-entry load tracker. Only one load is outstanding at a time.
// A store queue hit completes the load one cycle after acceptance. A miss
// issues a memory read and completes one cycle after its ack.

`timescale 1ns/100ps

module load_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ld_i,
  input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
  input  logic [lsu_pkg::TAG_W-1:0]  tag_i,
  input  logic                       fwd_hit_i,
  input  logic [lsu_pkg::DATA_W-1:0] fwd_data_i,
  input  logic                       rd_ack_i,
  input  logic [lsu_pkg::DATA_W-1:0] rd_data_i,
  output logic                       busy_o,
  output logic [lsu_pkg::ADDR_W-1:0] fwd_addr_o,
  output logic                       rd_req_o,
  output logic [lsu_pkg::ADDR_W-1:0] rd_addr_o,
  output logic                       result_vld_o,
  output logic [lsu_pkg::DATA_W-1:0] result_data_o,
  output logic [lsu_pkg::TAG_W-1:0]  result_tag_o
);

  logic                       busy_q;
  logic [lsu_pkg::ADDR_W-1:0] addr_q;
  logic [lsu_pkg::TAG_W-1:0]  tag_q;
  logic                       res_vld_q;
  logic [lsu_pkg::DATA_W-1:0] res_data_q;
  logic [lsu_pkg::TAG_W-1:0]  res_tag_q;
  logic                       fwd_done;
  logic                       mem_done;

  // the queue search runs on the incoming address in the acceptance cycle.
  assign fwd_addr_o = addr_i;
  assign fwd_done   = ld_i & fwd_hit_i;
  assign mem_done   = busy_q & rd_ack_i;

  // ********************************************************************
  // control
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q    <= 1'b0;
      res_vld_q <= 1'b0;
    end else begin
      res_vld_q <= fwd_done | mem_done;
      if (ld_i && !fwd_hit_i) begin
        busy_q <= 1'b1;
      end else if (mem_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // ********************************************************************
  // payload
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (ld_i) begin
      addr_q <= addr_i;
      tag_q  <= tag_i;
    end
    if (fwd_done) begin
      res_data_q <= fwd_data_i;
      res_tag_q  <= tag_i;
    end else if (mem_done) begin
      res_data_q <= rd_data_i;
      res_tag_q  <= tag_q;
    end
  end

  assign busy_o        = busy_q;
  assign rd_req_o      = busy_q;
  assign rd_addr_o     = addr_q;
  assign result_vld_o  = res_vld_q;
  assign result_data_o = res_data_q;
  assign result_tag_o  = res_tag_q;

  // the top level must hold off new operations while a read is outstanding.
  a_no_load_while_busy: assert property (@(posedge clk) disable iff (rst)
    ld_i |-> !busy_q);

endmodule

/* design/store_queue.sv */
// Circular store queue with tail, retire and head pointers.
// SQ_DEPTH must be a power of two, 2 or more. Addresses are compared in full
// because every access is one aligned word.
// Retired entries drain in order through a request/ack handshake.

`timescale 1ns/100ps

module store_queue #(
  parameter int SQ_DEPTH = lsu_pkg::SQ_DEPTH_DEFAULT
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push_i,
  input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
  input  logic [lsu_pkg::DATA_W-1:0] data_i,
  input  logic                       retire_i,
  input  logic [lsu_pkg::ADDR_W-1:0] fwd_addr_i,
  input  logic                       drain_ack_i,
  output logic                       full_o,
  output logic                       empty_o,
  output logic                       fwd_hit_o,
  output logic [lsu_pkg::DATA_W-1:0] fwd_data_o,
  output logic                       drain_req_o,
  output logic [lsu_pkg::ADDR_W-1:0] drain_addr_o,
  output logic [lsu_pkg::DATA_W-1:0] drain_data_o
);

  localparam int IDX_W = $clog2(SQ_DEPTH);

  // pointers carry one extra wrap bit so that full and empty differ.
  logic [IDX_W:0]               tail_q;
  logic [IDX_W:0]               ret_q;
  logic [IDX_W:0]               head_q;
  logic [IDX_W:0]               count;
  logic [lsu_pkg::ADDR_W-1:0]   addr_mem [SQ_DEPTH];
  logic [lsu_pkg::DATA_W-1:0]   data_mem [SQ_DEPTH];

  // ********************************************************************
  // pointers
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_q <= '0;
      ret_q  <= '0;
      head_q <= '0;
    end else begin
      if (push_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire_i) begin
        ret_q <= ret_q + 1'b1;
      end
      if (drain_ack_i) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      addr_mem[tail_q[IDX_W-1:0]] <= addr_i;
      data_mem[tail_q[IDX_W-1:0]] <= data_i;
    end
  end

  assign count   = tail_q - head_q;
  // count reaches SQ_DEPTH only when its top bit is set.
  assign full_o  = count[IDX_W];
  assign empty_o = (count == '0);

  // entries from head up to the retire pointer are retired and wait to drain.
  assign drain_req_o  = (head_q != ret_q);
  assign drain_addr_o = addr_mem[head_q[IDX_W-1:0]];
  assign drain_data_o = data_mem[head_q[IDX_W-1:0]];

  // ********************************************************************
  // forward search
  // ********************************************************************

  // walk from oldest to youngest so that the last match found is the youngest.
  // retired stores count too, since memory has not seen them yet.
  always_comb begin
    logic [IDX_W-1:0] slot;
    fwd_hit_o  = 1'b0;
    fwd_data_o = '0;
    slot       = '0;
    for (int i = 0; i < SQ_DEPTH; i++) begin
      slot = head_q[IDX_W-1:0] + i[IDX_W-1:0];
      if ((i[IDX_W:0] < count) && (addr_mem[slot] == fwd_addr_i)) begin
        fwd_hit_o  = 1'b1;
        fwd_data_o = data_mem[slot];
      end
    end
  end

  // ********************************************************************
  // assertions
  // ********************************************************************

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push_i |-> !full_o);

  a_no_retire_past_tail: assert property (@(posedge clk) disable iff (rst)
    retire_i |-> (ret_q != tail_q));

  // the port may hold the write for wait states, so the entry must not move.
  a_drain_stable: assert property (@(posedge clk) disable iff (rst)
    (drain_req_o && !drain_ack_i) |=>
      (drain_req_o && $stable(drain_addr_o) && $stable(drain_data_o)));

endmodule

/* design/lsu_pkg.sv */
// Shared widths and encodings for the load/store unit.
// Every access is one aligned 64-bit word. There are no byte enables and no partial overlap.
// The store queue depth must be a power of two, 2 or more.

package lsu_pkg;

  // ********************************************************************
  // widths
  // ********************************************************************

  // data word carried by stores and loads.
  localparam int DATA_W = 64;

  // byte address on the memory side.
  localparam int ADDR_W = 32;

  // immediate displacement, sign-extended to ADDR_W.
  localparam int DISP_W = 16;

  // result tag (physical register and ROB index).
  localparam int TAG_W = 6;

  localparam int SQ_DEPTH_DEFAULT = 8;

  // ********************************************************************
  // operation kind, as carried on op_is_st_i
  // ********************************************************************

  localparam logic OP_LOAD  = 1'b0;
  localparam logic OP_STORE = 1'b1;

endpackage
